// File: common/mem_test_defs.svh
// Widths and register map are fixed at build time and must match the host driver
`ifndef MEM_TEST_DEFS_SVH
`define MEM_TEST_DEFS_SVH

// Bus widths
`define MT_ADDR_W 32
`define MT_DATA_W 64
`define MT_CSR_W 64
`define MT_CSR_IDX_W 3

// Write-side register indices
`define MT_CSR_RUN 3'd0
`define MT_CSR_STATUS_ADDR 3'd1
`define MT_CSR_RD_BASE 3'd2
`define MT_CSR_WR_BASE 3'd3
`define MT_CSR_MASK 3'd4
`define MT_CSR_CTRL 3'd5
`define MT_CSR_PACE 3'd6

// Read-side register indices
`define MT_CSR_PARAMS 3'd0
`define MT_CSR_RD_COUNT 3'd4
`define MT_CSR_WR_COUNT 3'd5
`define MT_CSR_STATE 3'd7

// Control register fields
`define MT_CTRL_RD_EN 0
`define MT_CTRL_WR_EN 1
`define MT_CTRL_STRIDE_LO 16
`define MT_CTRL_STRIDE_HI 31

// Pace register fields
`define MT_PACE_RD_LO 0
`define MT_PACE_RD_HI 7
`define MT_PACE_WR_LO 8
`define MT_PACE_WR_HI 15

`endif

// File: common/mem_test_pkg.sv
// Types only; the defs header must be on the include path before this package compiles
`default_nettype none

`include "mem_test_defs.svh"

package mem_test_pkg;

    // Line address, one word per memory line
    typedef logic [`MT_ADDR_W-1:0] t_line_addr;

    // Event and cycle counters, one event per cycle at most
    typedef logic [31:0] t_counter;

    // Stride and rotating base offset
    typedef logic [15:0] t_stride;

    // Cycles between stream requests
    typedef logic [7:0] t_interval;

    // Run sequence, also read back by the host
    typedef enum logic [2:0]
    {
        RUN_IDLE,
        RUN_ACTIVE,
        RUN_DRAIN,
        RUN_STATUS,
        RUN_FINISH
    } t_run_state;

    // Request sources on the shared memory bus
    typedef enum logic [1:0]
    {
        SRC_RD,
        SRC_WR,
        SRC_STATUS
    } t_req_src;

endpackage

`default_nettype wire

// File: hdl/mem_test_regs.sv
// Writes have no back-pressure; unlisted read indices return zero
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_defs.svh"

module mem_test_regs
    import mem_test_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     csr_wr_en,
    input  wire logic [`MT_CSR_IDX_W-1:0] csr_wr_idx,
    input  wire logic [`MT_CSR_W-1:0]     csr_wr_data,
    input  wire logic [`MT_CSR_IDX_W-1:0] csr_rd_idx,
    output logic [`MT_CSR_W-1:0]          csr_rd_data,
    input  wire logic                     mem_rsp_valid,
    input  wire logic                     mem_rsp_write,
    input  wire t_run_state               run_state,
    output logic                          start,
    output t_counter                      run_cycles,
    output t_line_addr                    status_addr,
    output t_line_addr                    rd_base,
    output t_line_addr                    wr_base,
    output t_line_addr                    mask,
    output t_stride                       stride,
    output logic                          rd_enable,
    output logic                          wr_enable,
    output t_interval                     rd_interval,
    output t_interval                     wr_interval
);

    t_counter rd_count;
    t_counter wr_count;

    // ========================================
    // Configuration writes
    // ========================================

    always_ff @(posedge clk)
    begin
        // Region addresses carry no reset
        if (csr_wr_en && (csr_wr_idx == `MT_CSR_STATUS_ADDR))
        begin
            status_addr <= t_line_addr'(csr_wr_data);
        end
        if (csr_wr_en && (csr_wr_idx == `MT_CSR_RD_BASE))
        begin
            rd_base <= t_line_addr'(csr_wr_data);
        end
        if (csr_wr_en && (csr_wr_idx == `MT_CSR_WR_BASE))
        begin
            wr_base <= t_line_addr'(csr_wr_data);
        end

        if (reset)
        begin
            start       <= 1'b0;
            run_cycles  <= '0;
            mask        <= '0;
            stride      <= '0;
            rd_enable   <= 1'b0;
            wr_enable   <= 1'b0;
            rd_interval <= '0;
            wr_interval <= '0;
        end
        else
        begin
            // Run length write doubles as the start command
            start <= csr_wr_en && (csr_wr_idx == `MT_CSR_RUN);
            if (csr_wr_en && (csr_wr_idx == `MT_CSR_RUN))
            begin
                run_cycles <= t_counter'(csr_wr_data);
            end
            if (csr_wr_en && (csr_wr_idx == `MT_CSR_MASK))
            begin
                mask <= t_line_addr'(csr_wr_data);
            end
            if (csr_wr_en && (csr_wr_idx == `MT_CSR_CTRL))
            begin
                rd_enable <= csr_wr_data[`MT_CTRL_RD_EN];
                wr_enable <= csr_wr_data[`MT_CTRL_WR_EN];
                stride    <= csr_wr_data[`MT_CTRL_STRIDE_HI:`MT_CTRL_STRIDE_LO];
            end
            if (csr_wr_en && (csr_wr_idx == `MT_CSR_PACE))
            begin
                rd_interval <= csr_wr_data[`MT_PACE_RD_HI:`MT_PACE_RD_LO];
                wr_interval <= csr_wr_data[`MT_PACE_WR_HI:`MT_PACE_WR_LO];
            end
        end
    end

    // ========================================
    // Response counters
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            rd_count <= '0;
            wr_count <= '0;
        end
        else if (mem_rsp_valid)
        begin
            // Status line response lands in the write count too
            if (mem_rsp_write)
            begin
                wr_count <= wr_count + 1'b1;
            end
            else
            begin
                rd_count <= rd_count + 1'b1;
            end
        end
    end

    // Host read-back
    always_comb
    begin
        case (csr_rd_idx)
            `MT_CSR_PARAMS:   csr_rd_data = `MT_CSR_W'(`MT_ADDR_W);
            `MT_CSR_RD_COUNT: csr_rd_data = `MT_CSR_W'(rd_count);
            `MT_CSR_WR_COUNT: csr_rd_data = `MT_CSR_W'(wr_count);
            // FSM state in the low byte
            `MT_CSR_STATE:    csr_rd_data = `MT_CSR_W'(8'(run_state));
            default:          csr_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/run_control.sv
// Start is ignored unless idle; a zero cycle count still gives one active cycle
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_defs.svh"

module run_control
    import mem_test_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              start,
    input  wire t_counter          run_cycles,
    input  wire logic              rd_enable,
    input  wire logic              wr_enable,
    input  wire logic              issue,
    input  wire logic              mem_rsp_valid,
    input  wire logic              rd_req,
    input  wire logic              wr_req,
    input  wire logic              grant_status,
    output logic                   req_status,
    output logic [`MT_DATA_W-1:0]  status_data,
    output logic                   rd_run,
    output logic                   wr_run,
    output t_run_state             run_state,
    output logic                   busy
);

    t_counter cycles_rem;
    t_counter cycles_executed;
    t_counter outstanding;
    t_counter outstanding_next;
    logic     drained;

    // Requests on the bus minus responses back
    assign outstanding_next = outstanding + t_counter'(issue) - t_counter'(mem_rsp_valid);
    // Looking one cycle ahead lets busy drop right after the last response
    assign drained = (outstanding_next == '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outstanding <= '0;
        end
        else
        begin
            outstanding <= outstanding_next;
        end
    end

    // ========================================
    // Run sequencing
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_state       <= RUN_IDLE;
            req_status      <= 1'b0;
            cycles_rem      <= '0;
            cycles_executed <= '0;
        end
        else
        begin
            case (run_state)
                RUN_IDLE:
                begin
                    if (start)
                    begin
                        run_state       <= RUN_ACTIVE;
                        cycles_rem      <= run_cycles;
                        cycles_executed <= '0;
                    end
                end
                RUN_ACTIVE:
                begin
                    cycles_rem      <= cycles_rem - 1'b1;
                    cycles_executed <= cycles_executed + 1'b1;
                    // Last active cycle
                    if (cycles_rem <= t_counter'(1))
                    begin
                        run_state <= RUN_DRAIN;
                    end
                end
                RUN_DRAIN:
                begin
                    cycles_executed <= cycles_executed + 1'b1;
                    if (drained && !rd_req && !wr_req)
                    begin
                        run_state  <= RUN_STATUS;
                        req_status <= 1'b1;
                    end
                end
                RUN_STATUS:
                begin
                    // Count is frozen here, so status data holds steady
                    if (grant_status)
                    begin
                        run_state  <= RUN_FINISH;
                        req_status <= 1'b0;
                    end
                end
                RUN_FINISH:
                begin
                    // Wait for the status line response
                    if (drained)
                    begin
                        run_state <= RUN_IDLE;
                    end
                end
                default:
                begin
                    run_state <= RUN_IDLE;
                end
            endcase
        end
    end

    assign status_data = {32'b0, cycles_executed};
    assign rd_run = (run_state == RUN_ACTIVE) && rd_enable;
    assign wr_run = (run_state == RUN_ACTIVE) && wr_enable;
    assign busy   = (run_state != RUN_IDLE);

    // A response implies a request already on the bus
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (outstanding != '0));

endmodule

`default_nettype wire

// File: stream/stride_stream.sv
// Mask must be a contiguous low-order mask; region base plus offset is not range checked
`timescale 1ns/1ns
`default_nettype none

module stride_stream
    import mem_test_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       start,
    input  wire logic       run,
    input  wire t_line_addr region_base,
    input  wire t_line_addr mask,
    input  wire t_stride    stride,
    input  wire t_interval  interval,
    input  wire logic       grant,
    output logic            req,
    output t_line_addr      req_addr
);

    t_line_addr offset;
    t_line_addr offset_next;
    t_stride    base;
    t_stride    base_max;
    t_interval  pace_cnt;
    logic       wrap;

    // Candidate next offset and region overflow check
    assign offset_next = offset + t_line_addr'(stride);
    assign wrap = |(offset_next & ~mask);

    // Last rotating base before returning to zero
    assign base_max = (stride == '0) ? '0 : ((stride - 1'b1) & t_stride'(mask));

    // Request whenever running and the pace counter has run out
    assign req = run && (pace_cnt == '0);
    assign req_addr = region_base + offset;

    // ========================================
    // Address walk and pacing
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset || start)
        begin
            offset   <= '0;
            base     <= '0;
            pace_cnt <= '0;
        end
        else if (grant)
        begin
            pace_cnt <= interval;
            if (wrap)
            begin
                // Back to the region head, shifted by the rotating base
                offset <= t_line_addr'(base);
                if (base >= base_max)
                begin
                    base <= '0;
                end
                else
                begin
                    base <= base + 1'b1;
                end
            end
            else
            begin
                offset <= offset_next;
            end
        end
        else if (pace_cnt != '0)
        begin
            pace_cnt <= pace_cnt - 1'b1;
        end
    end

    // Arbiter relies on a held address until the grant arrives
    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        (req && !grant) |=> $stable(req_addr));

endmodule

`default_nettype wire

// File: hdl/mem_req_arbiter.sv
// One request per cycle at most; nothing is granted in a cycle with almost full high
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_defs.svh"

module mem_req_arbiter
    import mem_test_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  rd_req,
    input  wire logic                  wr_req,
    input  wire logic                  req_status,
    input  wire t_line_addr            rd_addr,
    input  wire t_line_addr            wr_addr,
    input  wire t_line_addr            status_addr,
    input  wire logic [`MT_DATA_W-1:0] status_data,
    input  wire logic                  mem_almost_full,
    output logic                       grant_rd,
    output logic                       grant_wr,
    output logic                       grant_status,
    output logic                       issue,
    output logic                       mem_req_valid,
    output logic                       mem_req_write,
    output t_line_addr                 mem_req_addr,
    output logic [`MT_DATA_W-1:0]      mem_req_data
);

    logic [2:0] req_vec;
    logic [2:0] grant_vec;
    t_req_src   last_src;

    // Bit order follows t_req_src
    assign req_vec = {req_status, wr_req, rd_req};

    // Round robin, search starts just after the last winner
    always_comb
    begin
        int cand;
        grant_vec = '0;
        for (int i = 1; i <= 3; i++)
        begin
            cand = (int'(last_src) + i) % 3;
            if (req_vec[cand] && (grant_vec == '0) && !mem_almost_full)
            begin
                grant_vec[cand] = 1'b1;
            end
        end
    end

    assign grant_rd     = grant_vec[SRC_RD];
    assign grant_wr     = grant_vec[SRC_WR];
    assign grant_status = grant_vec[SRC_STATUS];

    // ========================================
    // Registered request bus
    // ========================================

    always_ff @(posedge clk)
    begin
        // Payload follows the grant, valid alone is reset
        mem_req_write <= grant_wr || grant_status;
        mem_req_addr  <= grant_status ? status_addr : (grant_wr ? wr_addr : rd_addr);
        // Stream writes carry zero data
        mem_req_data  <= grant_status ? status_data : '0;

        if (reset)
        begin
            mem_req_valid <= 1'b0;
            last_src      <= SRC_STATUS;
        end
        else
        begin
            mem_req_valid <= |grant_vec;
            if (grant_rd)
            begin
                last_src <= SRC_RD;
            end
            else if (grant_wr)
            begin
                last_src <= SRC_WR;
            end
            else if (grant_status)
            begin
                last_src <= SRC_STATUS;
            end
        end
    end

    // Issue strobe for the outstanding count
    assign issue = mem_req_valid;

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant_vec));
    // Back-pressure seen in one cycle blocks the bus in the next
    a_no_issue_full: assert property (@(posedge clk) disable iff (reset)
        mem_almost_full |=> !mem_req_valid);

endmodule

`default_nettype wire

// File: hdl/mem_test_top.sv
// Memory must return exactly one response per request and accept one request per cycle
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_defs.svh"

module mem_test_top
    import mem_test_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     csr_wr_en,
    input  wire logic [`MT_CSR_IDX_W-1:0] csr_wr_idx,
    input  wire logic [`MT_CSR_W-1:0]     csr_wr_data,
    input  wire logic [`MT_CSR_IDX_W-1:0] csr_rd_idx,
    output logic [`MT_CSR_W-1:0]          csr_rd_data,
    output logic                          mem_req_valid,
    output logic                          mem_req_write,
    output t_line_addr                    mem_req_addr,
    output logic [`MT_DATA_W-1:0]         mem_req_data,
    input  wire logic                     mem_almost_full,
    input  wire logic                     mem_rsp_valid,
    input  wire logic                     mem_rsp_write,
    output logic                          busy
);

    // Configuration
    logic       start;
    t_counter   run_cycles;
    t_line_addr status_addr;
    t_line_addr rd_base;
    t_line_addr wr_base;
    t_line_addr mask;
    t_stride    stride;
    logic       rd_enable;
    logic       wr_enable;
    t_interval  rd_interval;
    t_interval  wr_interval;

    // Run control and arbitration
    t_run_state              run_state;
    logic                    rd_run;
    logic                    wr_run;
    logic                    issue;
    logic                    rd_req;
    logic                    wr_req;
    logic                    req_status;
    logic                    grant_rd;
    logic                    grant_wr;
    logic                    grant_status;
    t_line_addr              rd_addr;
    t_line_addr              wr_addr;
    logic [`MT_DATA_W-1:0]   status_data;

    mem_test_regs u_regs (
        .clk, .reset, .csr_wr_en, .csr_wr_idx, .csr_wr_data, .csr_rd_idx, .csr_rd_data,
        .mem_rsp_valid, .mem_rsp_write, .run_state, .start, .run_cycles,
        .status_addr, .rd_base, .wr_base, .mask, .stride,
        .rd_enable, .wr_enable, .rd_interval, .wr_interval
    );

    run_control u_run_control (
        .clk, .reset, .start, .run_cycles, .rd_enable, .wr_enable, .issue,
        .mem_rsp_valid, .rd_req, .wr_req, .grant_status, .req_status, .status_data,
        .rd_run, .wr_run, .run_state, .busy
    );

    // Read stream
    stride_stream u_rd_stream (
        .clk, .reset, .start,
        .run         (rd_run),
        .region_base (rd_base),
        .mask, .stride,
        .interval    (rd_interval),
        .grant       (grant_rd),
        .req         (rd_req),
        .req_addr    (rd_addr)
    );

    // Write stream
    stride_stream u_wr_stream (
        .clk, .reset, .start,
        .run         (wr_run),
        .region_base (wr_base),
        .mask, .stride,
        .interval    (wr_interval),
        .grant       (grant_wr),
        .req         (wr_req),
        .req_addr    (wr_addr)
    );

    mem_req_arbiter u_arbiter (
        .clk, .reset, .rd_req, .wr_req, .req_status, .rd_addr, .wr_addr,
        .status_addr, .status_data, .mem_almost_full,
        .grant_rd, .grant_wr, .grant_status, .issue,
        .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_data
    );

endmodule

`default_nettype wire

// File: tests/mem_test_tb.sv
// Responder gives at most one response per cycle; status line must lie outside both regions
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_defs.svh"

module mem_test_tb
    import mem_test_pkg::*;
();

    localparam int RUN_A = 60;
    localparam int RUN_B = 80;
    localparam int RUN_C = 50;
    localparam int WATCHDOG_CYCLES = (RUN_A + RUN_B + RUN_C) * 4 + 2000;
    localparam t_line_addr STATUS_LINE = 32'h0000_8000;
    localparam t_line_addr RD_REGION = 32'h0000_1000;
    localparam t_line_addr WR_REGION = 32'h0000_2000;
    localparam t_line_addr REGION_MASK = 32'h0000_001f;

    logic                     clk;
    logic                     reset;
    logic                     csr_wr_en;
    logic [`MT_CSR_IDX_W-1:0] csr_wr_idx;
    logic [`MT_CSR_W-1:0]     csr_wr_data;
    logic [`MT_CSR_IDX_W-1:0] csr_rd_idx;
    logic [`MT_CSR_W-1:0]     csr_rd_data;
    logic                     mem_req_valid;
    logic                     mem_req_write;
    t_line_addr               mem_req_addr;
    logic [`MT_DATA_W-1:0]    mem_req_data;
    logic                     mem_almost_full = 1'b0;
    logic                     mem_rsp_valid = 1'b0;
    logic                     mem_rsp_write = 1'b0;
    logic                     busy;

    int          errors = 0;
    int          cycle = 0;
    int          runs = 0;
    logic [31:0] seed = 32'h4031abfd;
    int          due_q[$];
    logic        wr_q[$];

    // Configuration as seen on the host bus
    t_line_addr cfg_status_addr = '0;
    t_line_addr cfg_rd_base = '0;
    t_line_addr cfg_wr_base = '0;
    t_line_addr cfg_mask = '0;
    t_stride    cfg_stride = '0;
    t_interval  cfg_wr_int = '0;
    t_counter   cfg_run_len = '0;

    // Reference stream state and per-run tallies
    t_line_addr rd_off = '0;
    t_line_addr wr_off = '0;
    t_stride    rd_rot = '0;
    t_stride    wr_rot = '0;
    int         rd_issued = 0;
    int         wr_issued = 0;
    int         status_cnt = 0;
    int         pending = 0;
    int         last_wr_cycle = 0;
    logic       wr_seen = 1'b0;
    t_line_addr exp_rd_addr;
    t_line_addr exp_wr_addr;
    logic       status_wr;
    logic       stream_wr;

    mem_test_top u_mem_test_top (
        .clk, .reset, .csr_wr_en, .csr_wr_idx, .csr_wr_data, .csr_rd_idx, .csr_rd_data,
        .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_data,
        .mem_almost_full, .mem_rsp_valid, .mem_rsp_write, .busy
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Stream rule, returns the next {base, offset}
    function automatic logic [47:0] model_step(input t_line_addr off, input t_stride rot,
                                               input t_stride step, input t_line_addr region_mask);
        t_line_addr nxt;
        t_stride    lim;
        t_stride    rot_next;
        nxt = off + t_line_addr'(step);
        lim = (step == '0) ? '0 : ((step - 16'd1) & region_mask[15:0]);
        if ((nxt & ~region_mask) == '0)
        begin
            return {rot, nxt};
        end
        // Outside the region, restart at the rotating base
        rot_next = (rot >= lim) ? '0 : rot + 16'd1;
        return {rot_next, t_line_addr'(rot)};
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ========================================
    // Memory responder
    // ========================================

    always @(posedge clk)
    begin
        int now;
        int hit;
        now = cycle;
        if (!reset && mem_req_valid)
        begin
            // Delay of 1 to 8 cycles
            seed = lcg_next(seed);
            due_q.push_back(now + 1 + int'(seed[30:28]));
            wr_q.push_back(mem_req_write);
        end
        #2;
        seed = lcg_next(seed);
        mem_almost_full = !reset && (seed[31:29] == 3'd0);
        hit = -1;
        foreach (due_q[i])
        begin
            if ((hit < 0) && (due_q[i] <= now + 1))
            begin
                hit = i;
            end
        end
        mem_rsp_valid = (hit >= 0);
        mem_rsp_write = (hit >= 0) ? wr_q[hit] : 1'b0;
        if (hit >= 0)
        begin
            due_q.delete(hit);
            wr_q.delete(hit);
        end
    end

    // ========================================
    // Bus monitor and reference model
    // ========================================

    assign exp_rd_addr = cfg_rd_base + rd_off;
    assign exp_wr_addr = cfg_wr_base + wr_off;
    assign status_wr = mem_req_valid && mem_req_write && (mem_req_addr == cfg_status_addr);
    assign stream_wr = mem_req_valid && mem_req_write && (mem_req_addr != cfg_status_addr);

    always @(posedge clk)
    begin
        pending <= reset ? 0 : pending + int'(mem_req_valid) - int'(mem_rsp_valid);
        if (csr_wr_en)
        begin
            case (csr_wr_idx)
                `MT_CSR_STATUS_ADDR: cfg_status_addr <= csr_wr_data[31:0];
                `MT_CSR_RD_BASE:     cfg_rd_base <= csr_wr_data[31:0];
                `MT_CSR_WR_BASE:     cfg_wr_base <= csr_wr_data[31:0];
                `MT_CSR_MASK:        cfg_mask <= csr_wr_data[31:0];
                `MT_CSR_CTRL:        cfg_stride <= csr_wr_data[31:16];
                `MT_CSR_PACE:        cfg_wr_int <= csr_wr_data[15:8];
                default:
                begin
                    // Run start, every stream restarts at offset 0
                    cfg_run_len <= csr_wr_data[31:0];
                    {rd_rot, rd_off} <= '0;
                    {wr_rot, wr_off} <= '0;
                    {rd_issued, wr_issued, status_cnt} <= '0;
                    wr_seen <= 1'b0;
                end
            endcase
        end
        if (!reset && mem_req_valid && !mem_req_write)
        begin
            {rd_rot, rd_off} <= model_step(rd_off, rd_rot, cfg_stride, cfg_mask);
            rd_issued <= rd_issued + 1;
        end
        if (!reset && status_wr)
        begin
            status_cnt <= status_cnt + 1;
        end
        if (!reset && stream_wr)
        begin
            {wr_rot, wr_off} <= model_step(wr_off, wr_rot, cfg_stride, cfg_mask);
            wr_issued <= wr_issued + 1;
            wr_seen <= 1'b1;
            last_wr_cycle <= cycle;
        end
    end

    a_rd_addr: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && !mem_req_write) |-> (mem_req_addr == exp_rd_addr))
        else begin errors++; $display("error mem_req_addr got %h expected %h",
            $sampled(mem_req_addr), $sampled(exp_rd_addr)); end
    a_wr_addr: assert property (@(posedge clk) disable iff (reset)
        stream_wr |-> (mem_req_addr == exp_wr_addr))
        else begin errors++; $display("error mem_req_addr got %h expected %h",
            $sampled(mem_req_addr), $sampled(exp_wr_addr)); end
    a_wr_data: assert property (@(posedge clk) disable iff (reset)
        stream_wr |-> (mem_req_data == '0))
        else begin errors++; $display("error mem_req_data got %h expected %h",
            $sampled(mem_req_data), 64'h0); end
    // Pacing keeps stream writes interval plus one apart
    a_wr_gap: assert property (@(posedge clk) disable iff (reset)
        (stream_wr && wr_seen) |-> ((cycle - last_wr_cycle) >= int'(cfg_wr_int) + 1))
        else begin errors++; $display("error mem_req_valid write gap got %h expected %h",
            $sampled(cycle - last_wr_cycle), $sampled(int'(cfg_wr_int) + 1)); end
    a_full_stall: assert property (@(posedge clk) disable iff (reset)
        mem_almost_full |=> !mem_req_valid)
        else begin errors++; $display("error mem_req_valid got %h expected %h", 1'b1, 1'b0); end
    a_status_once: assert property (@(posedge clk) disable iff (reset)
        status_wr |-> (status_cnt == 0))
        else begin errors++; $display("a second status write was issued in one run"); end
    a_status_value: assert property (@(posedge clk) disable iff (reset)
        status_wr |-> (mem_req_data[31:0] >= cfg_run_len))
        else begin errors++; $display("error mem_req_data got %h expected at least %h",
            $sampled(mem_req_data[31:0]), $sampled(cfg_run_len)); end
    a_status_last: assert property (@(posedge clk) disable iff (reset)
        (mem_req_valid && !status_wr) |-> (status_cnt == 0))
        else begin errors++; $display("a stream request followed the status write"); end
    a_busy_drained: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> ((pending == 0) && (status_cnt == 1)))
        else begin errors++; $display("busy fell with %0d responses open and %0d status writes",
            $sampled(pending), $sampled(status_cnt)); end

    // ========================================
    // Host stimulus
    // ========================================

    task automatic csr_write(input logic [2:0] idx, input logic [63:0] data);
        @(posedge clk);
        #2;
        csr_wr_en = 1'b1;
        csr_wr_idx = idx;
        csr_wr_data = data;
        @(posedge clk);
        #2;
        csr_wr_en = 1'b0;
    endtask

    task automatic check_reg(input logic [2:0] idx, input logic [63:0] expected,
                             input string name);
        @(posedge clk);
        #2;
        csr_rd_idx = idx;
        @(negedge clk);
        assert (csr_rd_data == expected)
        else begin errors++; $display("error csr_rd_data %s got %h expected %h",
            name, csr_rd_data, expected); end
    endtask

    // One complete run, then the count registers
    task automatic run_once(input logic rd_en, input logic wr_en, input t_stride step,
                            input t_interval rd_int, input t_interval wr_int, input int len);
        csr_write(`MT_CSR_CTRL, {32'h0, step, 14'h0, wr_en, rd_en});
        csr_write(`MT_CSR_PACE, {48'h0, wr_int, rd_int});
        csr_write(`MT_CSR_RUN, 64'(len));
        while (!busy) @(negedge clk);
        while (busy) @(negedge clk);
        runs++;
        check_reg(`MT_CSR_RD_COUNT, 64'(rd_issued), "rd_count");
        check_reg(`MT_CSR_WR_COUNT, 64'(wr_issued + 1), "wr_count");
        check_reg(`MT_CSR_STATE, 64'(RUN_IDLE), "state");
    endtask

    initial
    begin
        reset = 1'b1;
        csr_wr_en = 1'b0;
        csr_wr_idx = '0;
        csr_wr_data = '0;
        csr_rd_idx = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        assert (!busy)
        else begin errors++; $display("error busy got %h expected %h", busy, 1'b0); end
        assert (!mem_req_valid)
        else begin errors++; $display("error mem_req_valid got %h expected %h",
            mem_req_valid, 1'b0); end
        check_reg(`MT_CSR_RD_COUNT, 64'h0, "rd_count");
        check_reg(`MT_CSR_WR_COUNT, 64'h0, "wr_count");
        check_reg(`MT_CSR_PARAMS, 64'(`MT_ADDR_W), "params");

        csr_write(`MT_CSR_STATUS_ADDR, 64'(STATUS_LINE));
        csr_write(`MT_CSR_RD_BASE, 64'(RD_REGION));
        csr_write(`MT_CSR_WR_BASE, 64'(WR_REGION));
        csr_write(`MT_CSR_MASK, 64'(REGION_MASK));
        // Read only, stride 12 wraps often in 32 lines
        run_once(1'b1, 1'b0, 16'd12, 8'd0, 8'd0, RUN_A);
        // Write only, paced
        run_once(1'b0, 1'b1, 16'd5, 8'd0, 8'd3, RUN_B);
        // Both streams share the bus
        run_once(1'b1, 1'b1, 16'd7, 8'd1, 8'd2, RUN_C);

        $display("runs %0d errors %0d", runs, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, a run never finished", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/mem_test_pkg.sv
hdl/mem_test_regs.sv
hdl/run_control.sv
stream/stride_stream.sv
hdl/mem_req_arbiter.sv
hdl/mem_test_top.sv
tests/mem_test_tb.sv

// File: Makefile
# Verilator build and run of the memory traffic generator testbench

TOP = mem_test_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module mem_test_top

clean:
	rm -rf obj_dir sim.log
